// File: design/dsp_pkg.sv
package dsp_pkg;

    // lane layout.
    localparam int channel_width = 4;
    localparam int ffe_length = 3; // taps, no more than channel_width.

    // datapath precisions.
    localparam int code_precision = 8;
    localparam int weight_precision = 8;
    localparam int output_precision = 10;
    localparam int shift_precision = 4;
    localparam int sym_precision = 3;

    // config write port.
    localparam int cfg_addr_width = 5;
    localparam int cfg_data_width = 16;

    typedef logic signed [code_precision-1:0] code_t;
    typedef logic signed [weight_precision-1:0] weight_t;
    typedef logic signed [output_precision-1:0] est_t;
    typedef logic signed [sym_precision-1:0] sym_t;

    typedef logic [shift_precision-1:0] shift_t;
    typedef logic [$clog2(channel_width)-1:0] align_t; // lane offset for the aligner.

endpackage

// File: design/signed_buffer.sv
`timescale 1ns/1ns

module signed_buffer #(
    parameter type payload_t = logic signed [7:0],
    parameter int num_channels = 1,
    parameter int depth = 1
) (
    input  logic     clk,
    input  logic     reset,
    input  payload_t in [num_channels-1:0],
    output payload_t buffer [num_channels-1:0][depth:0]
);

    payload_t stages [num_channels-1:0][depth:1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int l = 0; l < num_channels; l++) begin
                for (int s = 1; s <= depth; s++) begin
                    stages[l][s] <= '0;
                end
            end
        end else begin
            for (int l = 0; l < num_channels; l++) begin
                stages[l][1] <= in[l];
                for (int s = 2; s <= depth; s++) begin
                    stages[l][s] <= stages[l][s-1]; // one stage per cycle.
                end
            end
        end
    end

    // stage 0 is the live input.
    for (genvar l = 0; l < num_channels; l++) begin : g_lane
        assign buffer[l][0] = in[l];
        for (genvar s = 1; s <= depth; s++) begin : g_stage
            assign buffer[l][s] = stages[l][s];
        end
    end

    a_depth_min: assert property (@(posedge clk) depth >= 1);

endmodule

// File: design/comb_ffe.sv
`timescale 1ns/1ns

module comb_ffe (
    input  dsp_pkg::code_t   codes_cur  [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::code_t   codes_prev [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::weight_t weights [dsp_pkg::ffe_length-1:0][dsp_pkg::channel_width-1:0],
    input  dsp_pkg::shift_t  ffe_shift [dsp_pkg::channel_width-1:0],
    output dsp_pkg::est_t    estimates [dsp_pkg::channel_width-1:0]
);

    import dsp_pkg::*;

    // full product width plus growth for the tap sum.
    localparam int prod_width = code_precision + weight_precision;
    localparam int acc_width = prod_width + $clog2(ffe_length) + 1;

    typedef logic signed [acc_width-1:0] acc_t;

    // previous vector in the low half, current vector in the high half.
    code_t window [2*channel_width-1:0];

    for (genvar l = 0; l < channel_width; l++) begin : g_window
        assign window[l] = codes_prev[l];
        assign window[l+channel_width] = codes_cur[l];
    end

    for (genvar lane = 0; lane < channel_width; lane++) begin : g_lane
        acc_t acc;

        // tap t reads lane-t, reaching into the previous vector when negative.
        always_comb begin
            acc = '0;
            for (int t = 0; t < ffe_length; t++) begin
                acc = acc + acc_t'(weights[t][lane]) * acc_t'(window[lane+channel_width-t]);
            end
        end

        assign estimates[lane] = est_t'(acc >>> ffe_shift[lane]); // arithmetic, then truncate.
    end

endmodule

// File: design/comb_comp.sv
`timescale 1ns/1ns

module comb_comp (
    input  dsp_pkg::est_t estimates [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::est_t slice_levels [2:0],
    output dsp_pkg::sym_t sym_out [dsp_pkg::channel_width-1:0]
);

    import dsp_pkg::*;

    for (genvar lane = 0; lane < channel_width; lane++) begin : g_lane
        logic [1:0] passed;

        // thresholds strictly below the estimate.
        always_comb begin
            passed = '0;
            for (int k = 0; k < 3; k++) begin
                if (estimates[lane] > slice_levels[k]) begin
                    passed = passed + 2'd1;
                end
            end
        end

        // count 0..3 maps to -3, -1, 1, 3.
        assign sym_out[lane] = sym_t'(2 * int'(passed) - 3);
    end

    // levels out of order would fold two PAM4 eyes together.
    always_comb begin
        if (!$isunknown({slice_levels[0], slice_levels[1], slice_levels[2]})) begin
            a_levels_ascending: assert (slice_levels[0] <= slice_levels[1] &&
                                        slice_levels[1] <= slice_levels[2]);
        end
    end

endmodule

// File: design/data_aligner.sv
`timescale 1ns/1ns

module data_aligner (
    input  dsp_pkg::sym_t   older [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::sym_t   newer [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::align_t align_pos,
    output dsp_pkg::sym_t   aligned [dsp_pkg::channel_width-1:0]
);

    import dsp_pkg::*;

    sym_t joined [2*channel_width-1:0];

    // older vector first, newer one above it.
    for (genvar l = 0; l < channel_width; l++) begin : g_join
        assign joined[l] = older[l];
        assign joined[l+channel_width] = newer[l];
    end

    // window of channel_width lanes starting at the offset.
    for (genvar k = 0; k < channel_width; k++) begin : g_pick
        assign aligned[k] = joined[int'(align_pos) + k];
    end

endmodule

// File: design/bits_estimator_datapath.sv
`timescale 1ns/1ns

module bits_estimator_datapath #(
    parameter int ffe_pipeline_depth = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  dsp_pkg::code_t   act_codes_in [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::weight_t weights [dsp_pkg::ffe_length-1:0][dsp_pkg::channel_width-1:0],
    input  dsp_pkg::shift_t  ffe_shift [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::est_t    slice_levels [2:0],
    input  dsp_pkg::align_t  align_pos,
    output dsp_pkg::code_t   act_codes_out [dsp_pkg::channel_width-1:0],
    output dsp_pkg::est_t    est_syms_out [dsp_pkg::channel_width-1:0],
    output dsp_pkg::sym_t    symbols_out [dsp_pkg::channel_width-1:0]
);

    import dsp_pkg::*;

    localparam int total_depth = ((ffe_pipeline_depth > 1) ? ffe_pipeline_depth : 1) + 1;

    code_t code_buffer [channel_width-1:0][total_depth:0];
    est_t  est_buffer  [channel_width-1:0][total_depth:0];
    sym_t  sym_buffer  [channel_width-1:0][1:0];

    code_t codes_cur [channel_width-1:0];
    code_t codes_prev [channel_width-1:0];
    est_t  estimates [channel_width-1:0];
    est_t  slicer_in [channel_width-1:0];
    sym_t  sym_now [channel_width-1:0];
    sym_t  sym_older [channel_width-1:0];
    sym_t  sym_newer [channel_width-1:0];

    // raw ADC codes.
    signed_buffer #(
        .payload_t    (code_t),
        .num_channels (channel_width),
        .depth        (total_depth)
    ) code_buff_i (
        .clk    (clk),
        .reset  (reset),
        .in     (act_codes_in),
        .buffer (code_buffer)
    );

    comb_ffe ffe_i (
        .codes_cur  (codes_cur),
        .codes_prev (codes_prev),
        .weights    (weights),
        .ffe_shift  (ffe_shift),
        .estimates  (estimates)
    );

    // equalized estimates.
    signed_buffer #(
        .payload_t    (est_t),
        .num_channels (channel_width),
        .depth        (total_depth)
    ) est_buff_i (
        .clk    (clk),
        .reset  (reset),
        .in     (estimates),
        .buffer (est_buffer)
    );

    comb_comp slicer_i (
        .estimates    (slicer_in),
        .slice_levels (slice_levels),
        .sym_out      (sym_now)
    );

    // symbol register, reads -1 once the estimates are cleared.
    signed_buffer #(
        .payload_t    (sym_t),
        .num_channels (channel_width),
        .depth        (1)
    ) sym_buff_i (
        .clk    (clk),
        .reset  (1'b0),
        .in     (sym_now),
        .buffer (sym_buffer)
    );

    data_aligner aligner_i (
        .older     (sym_older),
        .newer     (sym_newer),
        .align_pos (align_pos),
        .aligned   (symbols_out)
    );

    for (genvar l = 0; l < channel_width; l++) begin : g_lane
        assign codes_cur[l] = code_buffer[l][0];
        assign codes_prev[l] = code_buffer[l][1]; // vector n-1 for the cross-lane taps.
        assign slicer_in[l] = est_buffer[l][ffe_pipeline_depth];
        assign sym_older[l] = sym_buffer[l][1];
        assign sym_newer[l] = sym_buffer[l][0];
        assign act_codes_out[l] = code_buffer[l][total_depth];
        assign est_syms_out[l] = est_buffer[l][total_depth];
    end

endmodule

// File: design/dsp_config_regs.sv
`timescale 1ns/1ns

module dsp_config_regs (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 cfg_write,
    input  logic [dsp_pkg::cfg_addr_width-1:0]   cfg_addr,
    input  logic [dsp_pkg::cfg_data_width-1:0]   cfg_data,
    output dsp_pkg::weight_t weights [dsp_pkg::ffe_length-1:0][dsp_pkg::channel_width-1:0],
    output dsp_pkg::shift_t  ffe_shift [dsp_pkg::channel_width-1:0],
    output dsp_pkg::est_t    slice_levels [2:0]
);

    import dsp_pkg::*;

    // address map: weights, then lane shifts, then the three levels.
    localparam int shift_base = ffe_length * channel_width;
    localparam int level_base = shift_base + channel_width;
    localparam int last_addr = level_base + 2;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int t = 0; t < ffe_length; t++) begin
                for (int l = 0; l < channel_width; l++) begin
                    weights[t][l] <= (t == 0) ? weight_t'(1) : weight_t'(0); // pass-through.
                end
            end
            for (int l = 0; l < channel_width; l++) begin
                ffe_shift[l] <= '0;
            end
            slice_levels[0] <= est_t'(-32);
            slice_levels[1] <= est_t'(0);
            slice_levels[2] <= est_t'(32);
        end else if (cfg_write) begin
            for (int t = 0; t < ffe_length; t++) begin
                for (int l = 0; l < channel_width; l++) begin
                    if (int'(cfg_addr) == t * channel_width + l) begin
                        weights[t][l] <= cfg_data[weight_precision-1:0];
                    end
                end
            end
            for (int l = 0; l < channel_width; l++) begin
                if (int'(cfg_addr) == shift_base + l) begin
                    ffe_shift[l] <= cfg_data[shift_precision-1:0];
                end
            end
            for (int k = 0; k < 3; k++) begin
                if (int'(cfg_addr) == level_base + k) begin
                    slice_levels[k] <= cfg_data[output_precision-1:0];
                end
            end
        end
    end

    a_addr_in_map: assert property (@(posedge clk) disable iff (reset)
        cfg_write |-> int'(cfg_addr) <= last_addr);

endmodule

// File: design/rx_dsp_top.sv
`timescale 1ns/1ns

module rx_dsp_top #(
    parameter int ffe_pipeline_depth = 1
) (
    input  logic                               clk,
    input  logic                               reset,
    input  dsp_pkg::code_t                     act_codes_in [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::align_t                    align_pos,
    input  logic                               cfg_write,
    input  logic [dsp_pkg::cfg_addr_width-1:0] cfg_addr,
    input  logic [dsp_pkg::cfg_data_width-1:0] cfg_data,
    output dsp_pkg::code_t                     act_codes_out [dsp_pkg::channel_width-1:0],
    output dsp_pkg::est_t                      est_syms_out [dsp_pkg::channel_width-1:0],
    output dsp_pkg::sym_t                      symbols_out [dsp_pkg::channel_width-1:0]
);

    import dsp_pkg::*;

    weight_t weights [ffe_length-1:0][channel_width-1:0];
    shift_t  ffe_shift [channel_width-1:0];
    est_t    slice_levels [2:0];

    // config bank sits beside the datapath.
    dsp_config_regs cfg_regs_i (
        .clk          (clk),
        .reset        (reset),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .weights      (weights),
        .ffe_shift    (ffe_shift),
        .slice_levels (slice_levels)
    );

    bits_estimator_datapath #(
        .ffe_pipeline_depth (ffe_pipeline_depth)
    ) datapath_i (
        .clk           (clk),
        .reset         (reset),
        .act_codes_in  (act_codes_in),
        .weights       (weights),
        .ffe_shift     (ffe_shift),
        .slice_levels  (slice_levels),
        .align_pos     (align_pos),
        .act_codes_out (act_codes_out),
        .est_syms_out  (est_syms_out),
        .symbols_out   (symbols_out)
    );

endmodule

// File: sim/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// next state of the stimulus generator.
function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// keep the low bits of a value, sign extended.
function automatic int wrap_signed(input int value, input int bits);
    int shifted;
    shifted = value <<< (32 - bits);
    return shifted >>> (32 - bits);
endfunction

// one lane of the FFE, taps below lane 0 read the previous vector.
function automatic int ffe_lane(input int cur [channel_width], input int prev [channel_width],
                                input int w [ffe_length][channel_width], input int shift,
                                input int lane);
    int sum;
    int src;
    sum = 0;
    for (int t = 0; t < ffe_length; t++) begin
        src = lane - t;
        if (src < 0) begin
            sum += w[t][lane] * prev[src + channel_width];
        end else begin
            sum += w[t][lane] * cur[src];
        end
    end
    return wrap_signed(sum >>> shift, output_precision);
endfunction

function automatic int slice_symbol(input int est, input int lo, input int mid, input int hi);
    int passed;
    passed = int'(est > lo) + int'(est > mid) + int'(est > hi); // levels strictly below.
    return 2 * passed - 3;
endfunction

// lanes past the older vector spill into the newer one.
function automatic int aligned_lane(input int older [channel_width],
                                    input int newer [channel_width], input int pos, input int k);
    int idx;
    idx = pos + k;
    if (idx < channel_width) begin
        return older[idx];
    end
    return newer[idx - channel_width];
endfunction

`endif

// File: sim/tb_rx_dsp.sv
`timescale 1ns/1ns

module tb_rx_dsp;

    import dsp_pkg::*;

    localparam int ffe_depth = 1;
    localparam int out_latency = ((ffe_depth > 1) ? ffe_depth : 1) + 1;
    localparam int num_rows = 56;
    localparam int reset_timeout = 20;
    localparam int last_cfg_addr = (ffe_length + 1) * channel_width + 2;

    logic clk = 1'b0;
    logic reset = 1'b1;
    code_t act_codes_in [channel_width-1:0];
    align_t align_pos;
    logic cfg_write;
    logic [cfg_addr_width-1:0] cfg_addr;
    logic [cfg_data_width-1:0] cfg_data;
    code_t act_codes_out [channel_width-1:0];
    est_t est_syms_out [channel_width-1:0];
    sym_t symbols_out [channel_width-1:0];

    // stimulus rows.
    int row_code [num_rows][channel_width];
    int row_align [num_rows];
    bit row_wr [num_rows];
    int row_addr [num_rows];
    int row_data [num_rows];

    // model results per row, expected outputs per cycle.
    int est_row [num_rows][channel_width];
    int sym_row [num_rows][channel_width];
    int exp_code [num_rows][channel_width];
    int exp_est [num_rows][channel_width];
    int exp_sym [num_rows][channel_width];

    int model_w [ffe_length][channel_width]; // register map copy.
    int model_shift [channel_width];
    int model_lvl [3];

    int unsigned lcg_state = 36;
    int check_count = 0;
    int error_count = 0;
    bit released;

    `include "tb_ref_model.svh"

    rx_dsp_top #(
        .ffe_pipeline_depth (ffe_depth)
    ) u_rx_dsp_top (
        .clk           (clk),
        .reset         (reset),
        .act_codes_in  (act_codes_in),
        .align_pos     (align_pos),
        .cfg_write     (cfg_write),
        .cfg_addr      (cfg_addr),
        .cfg_data      (cfg_data),
        .act_codes_out (act_codes_out),
        .est_syms_out  (est_syms_out),
        .symbols_out   (symbols_out)
    );

    always #4 clk = ~clk;

    initial begin
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
    end

    task automatic check_value(input string what, input int got, input int expected);
        check_count++;
        if (got != expected) begin
            error_count++;
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    function automatic int next_code();
        lcg_state = lcg_next(lcg_state);
        return int'(code_t'(lcg_state >> 16));
    endfunction

    task automatic set_codes(input int n, input int c0, input int c1, input int c2, input int c3);
        row_code[n][0] = c0;
        row_code[n][1] = c1;
        row_code[n][2] = c2;
        row_code[n][3] = c3;
    endtask

    // addresses past the map never reach the DUT.
    task automatic add_write(input int n, input int addr, input int data);
        if (addr <= last_cfg_addr) begin
            row_wr[n] = 1'b1;
            row_addr[n] = addr;
            row_data[n] = data & 16'hffff;
        end
    endtask

    task automatic reset_model_cfg();
        for (int t = 0; t < ffe_length; t++) begin
            for (int l = 0; l < channel_width; l++) begin
                model_w[t][l] = (t == 0) ? 1 : 0;
            end
        end
        for (int l = 0; l < channel_width; l++) begin
            model_shift[l] = 0;
        end
        model_lvl[0] = -32;
        model_lvl[1] = 0;
        model_lvl[2] = 32;
    endtask

    task automatic write_model_cfg(input int addr, input int data);
        if (addr < ffe_length * channel_width) begin
            model_w[addr / channel_width][addr % channel_width] =
                wrap_signed(data, weight_precision);
        end else if (addr < (ffe_length + 1) * channel_width) begin
            model_shift[addr - ffe_length * channel_width] = data & ((1 << shift_precision) - 1);
        end else if (addr <= last_cfg_addr) begin
            model_lvl[addr - (ffe_length + 1) * channel_width] =
                wrap_signed(data, output_precision);
        end
    endtask

    task automatic build_table();
        int cur [channel_width];
        int prev [channel_width];
        int older [channel_width];
        int newer [channel_width];
        int src;
        for (int n = 0; n < num_rows; n++) begin
            for (int l = 0; l < channel_width; l++) begin
                row_code[n][l] = next_code();
            end
            row_align[n] = 0;
            row_wr[n] = 1'b0;
            row_addr[n] = 0;
            row_data[n] = 0;
        end
        set_codes(6, -32, 0, 32, -31); // around the reset levels.
        set_codes(7, -33, 1, 31, 33);
        set_codes(8, -128, 127, -1, 0);
        add_write(9, 18, 80);
        add_write(10, 17, 10);
        add_write(11, 16, -60);
        set_codes(12, -60, -59, -61, 10);
        set_codes(13, 9, 11, 80, 79);
        set_codes(14, 81, -128, 127, 10);
        add_write(15, 25, 7);
        // lanes 0 and 1 reach back into the previous vector.
        add_write(16, 4, -2);
        add_write(17, 5, 3);
        add_write(18, 8, 1);
        add_write(19, 9, -1);
        add_write(20, 0, 2);
        add_write(21, 2, 3);
        add_write(22, 3, 100);
        add_write(23, 6, -1);
        add_write(24, 11, 5);
        add_write(25, 14, 1);
        add_write(26, 15, 2);
        add_write(27, 12, 1);
        for (int n = 40; n < 52; n++) begin
            row_align[n] = 1 + (n % 3);
        end
        add_write(45, 30, 1);

        reset_model_cfg();
        for (int n = 0; n < num_rows; n++) begin
            for (int l = 0; l < channel_width; l++) begin
                cur[l] = row_code[n][l];
                prev[l] = (n > 0) ? row_code[n-1][l] : 0;
            end
            for (int l = 0; l < channel_width; l++) begin
                est_row[n][l] = ffe_lane(cur, prev, model_w, model_shift[l], l);
            end
            if (row_wr[n]) begin
                write_model_cfg(row_addr[n], row_data[n]);
            end
            // sliced one cycle later, so a write in this row already counts.
            for (int l = 0; l < channel_width; l++) begin
                sym_row[n][l] = slice_symbol(est_row[n][l], model_lvl[0], model_lvl[1],
                                             model_lvl[2]);
            end
        end

        for (int m = 0; m < num_rows; m++) begin
            src = m - ffe_depth - 1;
            for (int l = 0; l < channel_width; l++) begin
                exp_code[m][l] = (m >= out_latency) ? row_code[m - out_latency][l] : 0;
                exp_est[m][l] = (m >= out_latency) ? est_row[m - out_latency][l] : 0;
                older[l] = (src >= 0) ? sym_row[src][l] : -1;
                newer[l] = (src + 1 >= 0) ? sym_row[src + 1][l] : -1;
            end
            for (int k = 0; k < channel_width; k++) begin
                exp_sym[m][k] = aligned_lane(older, newer, row_align[m], k);
            end
        end
    endtask

    task automatic check_reset_outputs(input int cycle);
        for (int l = 0; l < channel_width; l++) begin
            check_value($sformatf("reset cycle %0d act_codes_out[%0d]", cycle, l),
                        int'(act_codes_out[l]), 0);
            check_value($sformatf("reset cycle %0d est_syms_out[%0d]", cycle, l),
                        int'(est_syms_out[l]), 0);
            check_value($sformatf("reset cycle %0d symbols_out[%0d]", cycle, l),
                        int'(symbols_out[l]), -1);
        end
    endtask

    task automatic wait_reset_release(output bit done);
        int cycles;
        done = 1'b0;
        cycles = 0;
        while (!done && cycles < reset_timeout) begin
            @(posedge clk);
            #3;
            cycles++;
            if (cycles >= 3) begin
                check_reset_outputs(cycles); // sym register settles after two edges.
            end
            done = !reset;
        end
    endtask

    task automatic run_table();
        for (int m = 0; m < num_rows; m++) begin
            @(posedge clk);
            #1;
            for (int l = 0; l < channel_width; l++) begin
                act_codes_in[l] = code_t'(row_code[m][l]);
            end
            align_pos = align_t'(row_align[m]);
            cfg_write = row_wr[m];
            cfg_addr = cfg_addr_width'(row_addr[m]);
            cfg_data = cfg_data_width'(row_data[m]);
            #2;
            for (int l = 0; l < channel_width; l++) begin
                check_value($sformatf("cycle %0d act_codes_out[%0d]", m, l),
                            int'(act_codes_out[l]), exp_code[m][l]);
                check_value($sformatf("cycle %0d est_syms_out[%0d]", m, l),
                            int'(est_syms_out[l]), exp_est[m][l]);
                check_value($sformatf("cycle %0d symbols_out[%0d]", m, l),
                            int'(symbols_out[l]), exp_sym[m][l]);
            end
        end
    endtask

    initial begin
        for (int l = 0; l < channel_width; l++) begin
            act_codes_in[l] = '0;
        end
        align_pos = '0;
        cfg_write = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        build_table();
        wait_reset_release(released);
        if (!released) begin
            $display("timeout: reset still asserted after %0d cycles", reset_timeout);
            $display("Something failed");
            $finish;
        end else begin
            run_table();
            $display("%0d checks, %0d errors", check_count, error_count);
            if (error_count == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule

// File: sim.f
+incdir+sim
design/dsp_pkg.sv
design/signed_buffer.sv
design/comb_ffe.sv
design/comb_comp.sv
design/data_aligner.sv
design/bits_estimator_datapath.sv
design/dsp_config_regs.sv
design/rx_dsp_top.sv
sim/tb_rx_dsp.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_rx_dsp
FILELIST := sim.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
PASS_MSG := Everything OK

SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard sim/*.svh)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
